// ==== common/fabric_settings.svh ====
`ifndef FABRIC_SETTINGS_SVH
`define FABRIC_SETTINGS_SVH

// fabric dimensions
`define FAB_NCLB      8
`define FAB_NEXTIN    8
`define FAB_NEXTOUT   8

// data path widths
`define FAB_WW        4
`define FAB_ACCW      8

// track bus layout
`define FAB_NTRACK    24
`define FAB_TRK_CLB   8
`define FAB_TRK_MAC   16

// clb frames take addresses 0 to FAB_NCLB-1
`define FAB_NFRAME    10
`define FAB_MAC_ADDR  8
`define FAB_IO_ADDR   9
`define FAB_FRAMEW    40

`endif

// ==== common/fabric_route_pkg.sv ====
`include "fabric_settings.svh"

package fabric_route_pkg;

   localparam int NWORD = `FAB_NTRACK / `FAB_WW; // 4-bit words on the bus

   typedef logic [`FAB_NTRACK-1:0]         track_vec_t;
   typedef logic [$clog2(`FAB_NTRACK)-1:0] track_sel_t;
   typedef logic [$clog2(NWORD)-1:0]       word_sel_t;

   // selects past the last track read as zero
   function automatic logic pick_track(track_vec_t t, track_sel_t s);
      return (s < `FAB_NTRACK) ? t[s] : 1'b0;
   endfunction

   function automatic logic [`FAB_WW-1:0] pick_word(track_vec_t t, word_sel_t w);
      return (w < NWORD) ? t[w*`FAB_WW +: `FAB_WW] : '0;
   endfunction

endpackage

// ==== common/fabric_cfg_pkg.sv ====
`include "fabric_settings.svh"

package fabric_cfg_pkg;

   localparam int CLB_NIN = 4; // lut inputs
   localparam int TSW     = $bits(fabric_route_pkg::track_sel_t);
   localparam int WSW     = $bits(fabric_route_pkg::word_sel_t);

   localparam int CLB_PADW = `FAB_FRAMEW - CLB_NIN*TSW - 2**CLB_NIN - 1;
   localparam int MAC_PADW = `FAB_FRAMEW - 2*WSW - 1;

   typedef logic [$clog2(`FAB_NFRAME)-1:0] cfg_addr_t;

   typedef struct packed {
      logic [CLB_PADW-1:0]                        pad;
      logic                                       carry_en;
      logic [2**CLB_NIN-1:0]                      lut;
      fabric_route_pkg::track_sel_t [CLB_NIN-1:0] sel;  // sel[0] lowest
   } clb_cfg_t;

   typedef struct packed {
      logic [MAC_PADW-1:0]         pad;
      logic                        acc_en;   // accumulate instead of load
      fabric_route_pkg::word_sel_t wsel_b;
      fabric_route_pkg::word_sel_t wsel_a;
   } mac_cfg_t;

   typedef struct packed {
      fabric_route_pkg::track_sel_t [`FAB_NEXTOUT-1:0] out_sel;
   } io_cfg_t;

   // each stored frame is read through the view of the block it drives
   typedef union packed {
      clb_cfg_t clb;
      mac_cfg_t mac;
      io_cfg_t  io;
   } cfg_frame_u;

endpackage

// ==== hw/config_store.sv ====
`timescale 1ns/1ps
`include "fabric_settings.svh"

module config_store (
   input  logic                       clk,
   input  logic                       arst_n,
   input  logic                       cfg_we,
   input  fabric_cfg_pkg::cfg_addr_t  cfg_addr,
   input  fabric_cfg_pkg::cfg_frame_u cfg_data,
   output fabric_cfg_pkg::cfg_frame_u clb_frames [`FAB_NCLB],
   output fabric_cfg_pkg::cfg_frame_u mac_frame,
   output fabric_cfg_pkg::cfg_frame_u io_frame
);
   import fabric_cfg_pkg::*;

   cfg_frame_u frames [`FAB_NFRAME];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < `FAB_NFRAME; i++) begin
            frames[i] <= '0;
         end
      end else if (cfg_we && (cfg_addr < `FAB_NFRAME)) begin
         frames[cfg_addr] <= cfg_data;
      end
   end

   // new config acts in the cycle after the write
   always_comb begin
      for (int i = 0; i < `FAB_NCLB; i++) begin
         clb_frames[i] = frames[i];
      end
   end

   assign mac_frame = frames[`FAB_MAC_ADDR];
   assign io_frame  = frames[`FAB_IO_ADDR];

   a_cfg_addr_legal : assert property (
      @(posedge clk) disable iff (!arst_n)
      cfg_we |-> (cfg_addr < `FAB_NFRAME)
   ) else $error("config write to frame %0d, beyond last frame", cfg_addr);

endmodule

// ==== clb/clb_tile.sv ====
`timescale 1ns/1ps
`include "fabric_settings.svh"

module clb_tile (
   input  logic                        clk,
   input  logic                        arst_n,
   input  fabric_cfg_pkg::cfg_frame_u  frame,
   input  fabric_route_pkg::track_vec_t tracks,
   input  logic                        cin,
   output logic                        q,
   output logic                        cout
);
   import fabric_cfg_pkg::*;
   import fabric_route_pkg::*;

   clb_cfg_t           cfg;
   logic [CLB_NIN-1:0] lut_in;
   logic               d;

   assign cfg = frame.clb;

   // input connection selection
   always_comb begin
      for (int i = 0; i < CLB_NIN; i++) begin
         lut_in[i] = pick_track(tracks, cfg.sel[i]);
      end
   end

   always_comb begin
      if (cfg.carry_en) begin
         // full adder on in0, in1 and the chain
         d    = lut_in[0] ^ lut_in[1] ^ cin;
         cout = (lut_in[0] & lut_in[1]) | (lut_in[0] & cin) | (lut_in[1] & cin);
      end else begin
         d    = cfg.lut[lut_in];
         cout = 1'b0;   // breaks the chain
      end
   end

   // registered output keeps routing loop free
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         q <= 1'b0;
      end else begin
         q <= d;
      end
   end

   // a tile in lut mode must never pass a carry on to the next tile
   a_cout_idle : assert property (
      @(posedge clk) disable iff (!arst_n)
      !cfg.carry_en |-> !cout
   ) else $error("carry out active in lut mode");

endmodule

// ==== mac/mac_tile.sv ====
`timescale 1ns/1ps
`include "fabric_settings.svh"

module mac_tile (
   input  logic                         clk,
   input  logic                         arst_n,
   input  fabric_cfg_pkg::cfg_frame_u   frame,
   input  fabric_route_pkg::track_vec_t tracks,
   output logic [`FAB_ACCW-1:0]         acc
);
   import fabric_cfg_pkg::*;
   import fabric_route_pkg::*;

   mac_cfg_t             cfg;
   logic [`FAB_WW-1:0]   a;
   logic [`FAB_WW-1:0]   b;
   logic [`FAB_ACCW-1:0] prod;

   assign cfg = frame.mac;

   // operand words straight off the track bus
   assign a = pick_word(tracks, cfg.wsel_a);
   assign b = pick_word(tracks, cfg.wsel_b);

   assign prod = `FAB_ACCW'(a) * `FAB_ACCW'(b);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         acc <= '0;
      end else if (cfg.acc_en) begin
         acc <= acc + prod;   // wraps mod 256
      end else begin
         acc <= prod;
      end
   end

   a_wsel_legal : assert property (
      @(posedge clk) disable iff (!arst_n)
      (cfg.wsel_a < NWORD) && (cfg.wsel_b < NWORD)
   ) else $error("mac word select beyond track bus, a %0d b %0d", cfg.wsel_a, cfg.wsel_b);

endmodule

// ==== hw/io_block.sv ====
`timescale 1ns/1ps
`include "fabric_settings.svh"

module io_block (
   input  fabric_cfg_pkg::cfg_frame_u   frame,
   input  fabric_route_pkg::track_vec_t tracks,
   output logic [`FAB_NEXTOUT-1:0]      ext_out
);
   import fabric_cfg_pkg::*;
   import fabric_route_pkg::*;

   io_cfg_t cfg;

   assign cfg = frame.io;

   // each pin picks any track with no register on the way out
   always_comb begin
      for (int i = 0; i < `FAB_NEXTOUT; i++) begin
         ext_out[i] = pick_track(tracks, cfg.out_sel[i]);
      end
   end

endmodule

// ==== hw/fpga_fabric.sv ====
`timescale 1ns/1ps
`include "fabric_settings.svh"

module fpga_fabric (
   input  logic                       clk,
   input  logic                       arst_n,
   input  logic                       cfg_we,
   input  fabric_cfg_pkg::cfg_addr_t  cfg_addr,
   input  fabric_cfg_pkg::cfg_frame_u cfg_data,
   input  logic [`FAB_NEXTIN-1:0]     ext_in,
   output logic [`FAB_NEXTOUT-1:0]    ext_out
);
   import fabric_cfg_pkg::*;
   import fabric_route_pkg::*;

   cfg_frame_u clb_frames [`FAB_NCLB];
   cfg_frame_u mac_frame;
   cfg_frame_u io_frame;

   track_vec_t           tracks;
   wire [`FAB_NCLB-1:0]  clb_q;
   wire [`FAB_NCLB:0]    carry;   // top bit is the open end of the chain
   logic [`FAB_ACCW-1:0] acc;

   config_store i_config_store (
      .clk        (clk),
      .arst_n     (arst_n),
      .cfg_we     (cfg_we),
      .cfg_addr   (cfg_addr),
      .cfg_data   (cfg_data),
      .clb_frames (clb_frames),
      .mac_frame  (mac_frame),
      .io_frame   (io_frame)
   );

   // flat track bus holds pins then clb registers then accumulator
   always_comb begin
      tracks = '0;
      tracks[0 +: `FAB_NEXTIN]          = ext_in;
      tracks[`FAB_TRK_CLB +: `FAB_NCLB] = clb_q;
      tracks[`FAB_TRK_MAC +: `FAB_ACCW] = acc;
   end

   assign carry[0] = 1'b0;

   // carry ripples up in block order from clb 0
   for (genvar k = 0; k < `FAB_NCLB; k++) begin : g_clb
      clb_tile i_clb (
         .clk    (clk),
         .arst_n (arst_n),
         .frame  (clb_frames[k]),
         .tracks (tracks),
         .cin    (carry[k]),
         .q      (clb_q[k]),
         .cout   (carry[k+1])
      );
   end

   mac_tile i_mac (
      .clk    (clk),
      .arst_n (arst_n),
      .frame  (mac_frame),
      .tracks (tracks),
      .acc    (acc)
   );

   io_block i_io (
      .frame   (io_frame),
      .tracks  (tracks),
      .ext_out (ext_out)
   );

endmodule

// ==== testbench/fpga_fabric_tb.sv ====
`timescale 1ns/1ps
`include "fabric_settings.svh"

module fpga_fabric_tb;

   // frame field positions
   localparam int SELW       = 5;
   localparam int LUT_LSB    = 20;
   localparam int CE_BIT     = 36;
   localparam int ACC_EN_BIT = 6;

   localparam int N_RST   = 20;
   localparam int N_LUT   = 300;
   localparam int N_CARRY = 200;
   localparam int N_MAC   = 100;
   localparam int N_RECFG = 400;
   // frame writes of the directed phases plus reset
   localparam int N_SETUP      = 2 + 9 + 9 + 3;
   localparam int TOTAL_CYCLES = N_SETUP + N_RST + N_LUT + N_CARRY + 2*N_MAC + N_RECFG;
   localparam int WATCHDOG_NS  = TOTAL_CYCLES * 10 + 500;

   logic                       clk;
   logic                       arst_n;
   logic                       cfg_we;
   logic [3:0]                 cfg_addr;
   logic [`FAB_FRAMEW-1:0]     cfg_data;
   logic [`FAB_NEXTIN-1:0]     ext_in;
   logic [`FAB_NEXTOUT-1:0]    ext_out;

   integer seed = 32'h88a1_08f6;
   int     checks = 0;
   int     errors = 0;

   // model state
   logic [`FAB_FRAMEW-1:0] m_frame [`FAB_NFRAME];
   logic [`FAB_NCLB-1:0]   m_q;
   logic [`FAB_ACCW-1:0]   m_acc;
   logic [`FAB_NEXTIN-1:0] cur_ext;
   logic [`FAB_NEXTIN-1:0] prev_ext;

   fpga_fabric i_dut (
      .clk      (clk),
      .arst_n   (arst_n),
      .cfg_we   (cfg_we),
      .cfg_addr (cfg_addr),
      .cfg_data (cfg_data),
      .ext_in   (ext_in),
      .ext_out  (ext_out)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic int rand_below(int n);
      return $unsigned($random(seed)) % n;
   endfunction

   function automatic logic [`FAB_FRAMEW-1:0] rand_clb_frame(logic carry_en);
      logic [`FAB_FRAMEW-1:0] f;
      f = '0;
      for (int j = 0; j < 4; j++) begin
         f[SELW*j +: SELW] = rand_below(`FAB_NTRACK);
      end
      f[LUT_LSB +: 16] = rand_below(65536);
      f[CE_BIT]        = carry_en;
      return f;
   endfunction

   function automatic logic [`FAB_FRAMEW-1:0] rand_mac_frame(logic acc_en);
      logic [`FAB_FRAMEW-1:0] f;
      f = '0;
      f[2:0]        = rand_below(6);   // word a
      f[5:3]        = rand_below(6);   // word b
      f[ACC_EN_BIT] = acc_en;
      return f;
   endfunction

   function automatic logic [`FAB_FRAMEW-1:0] rand_io_frame();
      logic [`FAB_FRAMEW-1:0] f;
      for (int i = 0; i < `FAB_NEXTOUT; i++) begin
         f[SELW*i +: SELW] = rand_below(`FAB_NTRACK);
      end
      return f;
   endfunction

   // pin i reads track base+i
   function automatic logic [`FAB_FRAMEW-1:0] io_frame_from(int base);
      logic [`FAB_FRAMEW-1:0] f;
      for (int i = 0; i < `FAB_NEXTOUT; i++) begin
         f[SELW*i +: SELW] = base + i;
      end
      return f;
   endfunction

   function automatic logic [`FAB_NTRACK-1:0] model_tracks(logic [`FAB_NEXTIN-1:0] x);
      return {m_acc, m_q, x};
   endfunction

   function automatic logic [`FAB_NEXTOUT-1:0] predict_out(logic [`FAB_NTRACK-1:0] t);
      logic [`FAB_FRAMEW-1:0]  f;
      logic [`FAB_NEXTOUT-1:0] o;
      f = m_frame[`FAB_IO_ADDR];
      for (int i = 0; i < `FAB_NEXTOUT; i++) begin
         o[i] = t[f[SELW*i +: SELW]];
      end
      return o;
   endfunction

   // register update at the coming rising edge followed by the frame write
   task automatic model_clock(input logic [`FAB_NTRACK-1:0] t, input logic we,
                              input logic [3:0] addr, input logic [`FAB_FRAMEW-1:0] data);
      logic [`FAB_FRAMEW-1:0] f;
      logic [3:0]             in;
      logic                   c;
      logic [`FAB_NCLB-1:0]   nq;
      logic [3:0]             a;
      logic [3:0]             b;
      c = 1'b0;
      for (int k = 0; k < `FAB_NCLB; k++) begin
         f = m_frame[k];
         for (int j = 0; j < 4; j++) begin
            in[j] = t[f[SELW*j +: SELW]];
         end
         if (f[CE_BIT]) begin
            nq[k] = in[0] ^ in[1] ^ c;
            c     = (in[0] & in[1]) | (in[0] & c) | (in[1] & c);
         end else begin
            nq[k] = f[LUT_LSB + in];
            c     = 1'b0;
         end
      end
      f = m_frame[`FAB_MAC_ADDR];
      a = t[4*f[2:0] +: 4];
      b = t[4*f[5:3] +: 4];
      if (f[ACC_EN_BIT]) begin
         m_acc = m_acc + {4'b0, a} * {4'b0, b};
      end else begin
         m_acc = {4'b0, a} * {4'b0, b};
      end
      m_q = nq;
      if (we) begin
         m_frame[addr] = data;
      end
   endtask

   // one cycle driven after the edge and compared at the falling edge
   task automatic step(input logic [`FAB_NEXTIN-1:0] x, input logic we,
                       input logic [3:0] addr, input logic [`FAB_FRAMEW-1:0] data);
      logic [`FAB_NTRACK-1:0]  t;
      logic [`FAB_NEXTOUT-1:0] exp;
      @(posedge clk);
      #1;
      prev_ext = cur_ext;
      cur_ext  = x;
      ext_in   = x;
      cfg_we   = we;
      cfg_addr = addr;
      cfg_data = data;
      @(negedge clk);
      t   = model_tracks(x);
      exp = predict_out(t);
      checks++;
      if (ext_out !== exp) begin
         errors++;
         $display("mismatch at %0t: ext_out %h, model expects %h", $time, ext_out, exp);
      end
      model_clock(t, we, addr, data);
   endtask

   task automatic write_frame(input logic [3:0] addr, input logic [`FAB_FRAMEW-1:0] data);
      step(rand_below(256), 1'b1, addr, data);
   endtask

   task automatic idle_cycle();
      step(rand_below(256), 1'b0, '0, '0);
   endtask

   initial begin
      logic [`FAB_FRAMEW-1:0] f;
      logic [`FAB_NEXTIN-1:0] x;
      logic [`FAB_NEXTIN-1:0] sum;
      logic [3:0]             addr;

      arst_n   = 1'b0;
      cfg_we   = 1'b0;
      cfg_addr = '0;
      cfg_data = '0;
      ext_in   = '0;
      cur_ext  = '0;
      prev_ext = '0;
      m_q      = '0;
      m_acc    = '0;
      for (int i = 0; i < `FAB_NFRAME; i++) begin
         m_frame[i] = '0;
      end
      repeat (2) @(posedge clk);
      #1 arst_n = 1'b1;

      // reset config routes pin 0 everywhere
      for (int n = 0; n < N_RST; n++) begin
         x = rand_below(256);
         step(x, 1'b0, '0, '0);
         if (ext_out !== {`FAB_NEXTOUT{x[0]}}) begin
            errors++;
            $display("mismatch at %0t: reset config gives %h for ext_in %h", $time, ext_out, x);
         end
      end

      // lookup tables
      for (int k = 0; k < `FAB_NCLB; k++) begin
         write_frame(k, rand_clb_frame(1'b0));
      end
      write_frame(`FAB_IO_ADDR, rand_io_frame());
      repeat (N_LUT) idle_cycle();

      // carry chain adds ext_in to itself rotated right by 3
      for (int k = 0; k < `FAB_NCLB; k++) begin
         f = rand_clb_frame(1'b1);
         f[0 +: SELW]    = k;
         f[SELW +: SELW] = (k + 3) % 8;
         f[2*SELW +: SELW] = rand_below(`FAB_NEXTIN);
         f[3*SELW +: SELW] = rand_below(`FAB_NEXTIN);
         write_frame(k, f);
      end
      write_frame(`FAB_IO_ADDR, io_frame_from(`FAB_TRK_CLB));
      for (int n = 0; n < N_CARRY; n++) begin
         idle_cycle();
         sum = prev_ext + {prev_ext[2:0], prev_ext[7:3]};
         if (ext_out !== sum) begin
            errors++;
            $display("mismatch at %0t: carry sum %h, expected %h", $time, ext_out, sum);
         end
      end

      // multiply-accumulate loads first and accumulates after
      write_frame(`FAB_IO_ADDR, io_frame_from(`FAB_TRK_MAC));
      write_frame(`FAB_MAC_ADDR, rand_mac_frame(1'b0));
      repeat (N_MAC) idle_cycle();
      write_frame(`FAB_MAC_ADDR, rand_mac_frame(1'b1));
      repeat (N_MAC) idle_cycle();

      // writes interleaved with traffic
      for (int n = 0; n < N_RECFG; n++) begin
         if (rand_below(4) == 0) begin
            addr = rand_below(`FAB_NFRAME);
            if (addr < `FAB_NCLB) begin
               f = rand_clb_frame(rand_below(2));
            end else if (addr == `FAB_MAC_ADDR) begin
               f = rand_mac_frame(rand_below(2));
            end else begin
               f = rand_io_frame();
            end
            write_frame(addr, f);
         end else begin
            idle_cycle();
         end
      end

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired, the tests did not finish within %0d ns", WATCHDOG_NS);
      $display("Something failed");
      $finish;
   end

endmodule

// ==== project.f ====
+incdir+common
common/fabric_route_pkg.sv
common/fabric_cfg_pkg.sv
hw/config_store.sv
clb/clb_tile.sv
mac/mac_tile.sv
hw/io_block.sv
hw/fpga_fabric.sv
testbench/fpga_fabric_tb.sv

// ==== Makefile ====
TOP = fpga_fabric_tb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) \
		-Mdir obj_dir -o sim_$(TOP)

run: build
	./obj_dir/sim_$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

lint:
	verilator --lint-only --timing -f project.f --top-module fpga_fabric

clean:
	rm -rf obj_dir $(LOG)
